/* run.sh */
#!/bin/sh
# Compile and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_frontend -f src.f -o sim_frontend

# Checker errors are counted by the testbench, so the run is not cut short
out=$(./obj_dir/sim_frontend +verilator+error+limit+1000) || true
echo "$out"

echo "$out" | grep -qx "Testbench passed"

/* src.f */
src/frontend_pkg.sv
src/fetch_pc_gen.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/decode_stage.sv
src/issue_fifo.sv
src/frontend_top.sv
verif/frontend_checker.sv
verif/tb_frontend.sv

/* src/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic [1:0]                    fetch_valid_i,
  input  frontend_pkg::addr_t           fetch_pc_i,
  input  frontend_pkg::word_t [1:0]     fetch_words_i,
  input  frontend_pkg::fetch_excp_t     fetch_excp_i,
  input  logic                          wr_ready_i,
  output logic                          take_o,
  output logic [1:0]                    wr_num_o,
  output frontend_pkg::inst_pkt_t [1:0] wr_pkt_o
);

  logic [1:0]                    valid_q;
  frontend_pkg::addr_t           pc_q;
  frontend_pkg::word_t [1:0]     words_q;
  logic                          adef_q;
  frontend_pkg::inst_pkt_t [1:0] pkt;

  assign take_o = wr_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      valid_q <= 2'b00;
    end else if (wr_ready_i) begin
      valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ready_i) begin
      pc_q    <= fetch_pc_i;
      words_q <= fetch_words_i;
      adef_q  <= fetch_excp_i.adef;
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_slot
    frontend_pkg::inst_class_e cls;
    frontend_pkg::reg_info_t   reg_info;

    inst_decoder u_dec (
      .inst_i     (words_q[p]),
      .cls_o      (cls),
      .reg_info_o (reg_info)
    );

    always_comb begin
      pkt[p].pc        = {pc_q[31:3], 1'(p), pc_q[1:0]}; // Slot picks bit 2
      pkt[p].inst      = words_q[p];
      pkt[p].cls       = cls;
      pkt[p].reg_info  = reg_info;
      pkt[p].imm       = words_q[p][25:0];
      pkt[p].excp.adef = adef_q;
      pkt[p].excp.ine  = (cls == frontend_pkg::ILLEGAL);
    end
  end

  assign wr_num_o = 2'(valid_q[0]) + 2'(valid_q[1]);

  // First valid packet goes to lane 0
  assign wr_pkt_o[0] = valid_q[0] ? pkt[0] : pkt[1];
  assign wr_pkt_o[1] = pkt[1];

endmodule

/* src/fetch_pc_gen.sv */
`timescale 1ns/1ns

module fetch_pc_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                redirect_i,
  input  frontend_pkg::addr_t redirect_pc_i,
  input  logic                wait_i,
  input  logic                int_i,
  input  logic                advance_i,
  output frontend_pkg::addr_t pc_o,
  output logic [1:0]          valid_mask_o,
  output logic                stall_o
);

  frontend_pkg::addr_t pc_q;
  logic                pc_valid_q;
  logic                stall_q;

  // Redirect target loaded as is, low bits included
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= frontend_pkg::RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (advance_i) begin
      pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  // First cycle out of reset issues nothing
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_valid_q <= 1'b0;
    end else begin
      pc_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stall_q <= 1'b0;
    end else if (wait_i && !int_i) begin
      stall_q <= 1'b1;
    end else if (int_i) begin
      stall_q <= 1'b0; // Interrupt wakes the front end
    end
  end

  always_comb begin
    if (!pc_valid_q) begin
      valid_mask_o = 2'b00;
    end else if (pc_q[2]) begin
      valid_mask_o = 2'b10; // Entered at the upper slot
    end else begin
      valid_mask_o = 2'b11;
    end
  end

  assign pc_o    = pc_q;
  assign stall_o = stall_q;

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  frontend_pkg::addr_t           pc_i,
  input  logic [1:0]                    valid_mask_i,
  input  logic                          stall_i,
  output logic                          advance_o,
  output logic                          imem_req_o,
  output frontend_pkg::addr_t           imem_addr_o,
  input  logic                          imem_resp_valid_i,
  input  frontend_pkg::word_t [1:0]     imem_resp_data_i,
  input  logic                          take_i,
  output logic [1:0]                    fetch_valid_o,
  output frontend_pkg::addr_t           fetch_pc_o,
  output frontend_pkg::word_t [1:0]     fetch_words_o,
  output frontend_pkg::fetch_excp_t     fetch_excp_o
);

  logic                      busy_q;
  logic                      stale_q;
  frontend_pkg::addr_t       req_pc_q;
  logic [1:0]                req_mask_q;
  logic                      req_adef_q;
  logic [1:0]                out_valid_q;
  frontend_pkg::addr_t       out_pc_q;
  frontend_pkg::word_t [1:0] out_words_q;
  frontend_pkg::fetch_excp_t out_excp_q;
  logic                      issue;
  logic                      resp_ok;

  // Take also frees the output register, so ready covers both conditions
  assign issue = (|valid_mask_i) && !busy_q && !stall_i && !flush_i && take_i;

  assign advance_o   = issue;
  assign imem_req_o  = issue;
  assign imem_addr_o = {pc_i[31:3], 3'b000};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (issue) begin
      busy_q <= 1'b1;
    end else if (imem_resp_valid_i) begin
      busy_q <= 1'b0;
    end
  end

  // Request in flight across a flush has its response dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stale_q <= 1'b0;
    end else if (imem_resp_valid_i) begin
      stale_q <= 1'b0;
    end else if (flush_i && busy_q) begin
      stale_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc_q   <= pc_i;
      req_mask_q <= valid_mask_i;
      req_adef_q <= |pc_i[1:0];
    end
  end

  assign resp_ok = imem_resp_valid_i && !stale_q && !flush_i;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      out_valid_q <= 2'b00;
    end else if (resp_ok) begin
      out_valid_q <= req_mask_q;
    end else if (take_i) begin
      out_valid_q <= 2'b00;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_ok) begin
      out_pc_q        <= req_pc_q;
      out_words_q     <= imem_resp_data_i;
      out_excp_q.adef <= req_adef_q;
      out_excp_q.ine  <= 1'b0; // Set later by decode
    end
  end

  assign fetch_valid_o = out_valid_q;
  assign fetch_pc_o    = out_pc_q;
  assign fetch_words_o = out_words_q;
  assign fetch_excp_o  = out_excp_q;

endmodule

/* src/frontend_pkg.sv */
package frontend_pkg;

  localparam logic [31:0] RESET_PC = 32'h1c000000;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // Exception flags carried with each fetched pair
  typedef struct packed {
    logic adef; // PC not word aligned
    logic ine;  // Illegal instruction
  } fetch_excp_t;

  typedef enum logic [3:0] {
    ILLEGAL,
    ALU_3R,
    ALU_I12,
    LOAD,
    STORE,
    LUI,
    BRANCH,
    JUMP,
    JUMP_LINK
  } inst_class_e;

  // Zero index means the port is unused
  typedef struct packed {
    reg_idx_t r0;
    reg_idx_t r1;
    reg_idx_t w;
  } reg_info_t;

  // Issue FIFO payload
  typedef struct packed {
    addr_t       pc;
    word_t       inst;
    inst_class_e cls;
    reg_info_t   reg_info;
    logic [25:0] imm;
    fetch_excp_t excp;
  } inst_pkt_t;

endpackage

/* src/frontend_top.sv */
`timescale 1ns/1ns

module frontend_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  output logic                          imem_req_o,
  output frontend_pkg::addr_t           imem_addr_o,
  input  logic                          imem_resp_valid_i,
  input  frontend_pkg::word_t [1:0]     imem_resp_data_i,
  input  logic                          redirect_i,
  input  frontend_pkg::addr_t           redirect_pc_i,
  input  logic                          wait_i,
  input  logic                          int_i,
  output logic [1:0]                    issue_valid_o,
  output frontend_pkg::inst_pkt_t [1:0] issue_pkt_o,
  input  logic [1:0]                    issue_take_i
);

  frontend_pkg::addr_t           pc;
  logic [1:0]                    valid_mask;
  logic                          stall;
  logic                          advance;
  logic                          take;
  logic [1:0]                    fetch_valid;
  frontend_pkg::addr_t           fetch_pc;
  frontend_pkg::word_t [1:0]     fetch_words;
  frontend_pkg::fetch_excp_t     fetch_excp;
  logic                          wr_ready;
  logic [1:0]                    wr_num;
  frontend_pkg::inst_pkt_t [1:0] wr_pkt;

  fetch_pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .wait_i        (wait_i),
    .int_i         (int_i),
    .advance_i     (advance),
    .pc_o          (pc),
    .valid_mask_o  (valid_mask),
    .stall_o       (stall)
  );

  fetch_unit u_fetch (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush_i           (redirect_i),
    .pc_i              (pc),
    .valid_mask_i      (valid_mask),
    .stall_i           (stall),
    .advance_o         (advance),
    .imem_req_o        (imem_req_o),
    .imem_addr_o       (imem_addr_o),
    .imem_resp_valid_i (imem_resp_valid_i),
    .imem_resp_data_i  (imem_resp_data_i),
    .take_i            (take),
    .fetch_valid_o     (fetch_valid),
    .fetch_pc_o        (fetch_pc),
    .fetch_words_o     (fetch_words),
    .fetch_excp_o      (fetch_excp)
  );

  decode_stage u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (redirect_i),
    .fetch_valid_i (fetch_valid),
    .fetch_pc_i    (fetch_pc),
    .fetch_words_i (fetch_words),
    .fetch_excp_i  (fetch_excp),
    .wr_ready_i    (wr_ready),
    .take_o        (take),
    .wr_num_o      (wr_num),
    .wr_pkt_o      (wr_pkt)
  );

  issue_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (redirect_i),
    .wr_num_i   (wr_num),
    .wr_pkt_i   (wr_pkt),
    .wr_ready_o (wr_ready),
    .rd_valid_o (issue_valid_o),
    .rd_pkt_o   (issue_pkt_o),
    .rd_take_i  (issue_take_i)
  );

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
  input  frontend_pkg::word_t       inst_i,
  output frontend_pkg::inst_class_e cls_o,
  output frontend_pkg::reg_info_t   reg_info_o
);

  frontend_pkg::reg_idx_t rd;
  frontend_pkg::reg_idx_t rj;
  frontend_pkg::reg_idx_t rk;
  logic [16:0]            op17;
  logic [9:0]             op10;
  logic [6:0]             op7;
  logic [5:0]             op6;

  assign rd = inst_i[4:0];
  assign rj = inst_i[9:5];
  assign rk = inst_i[14:10];

  assign op17 = inst_i[31:15];
  assign op10 = inst_i[31:22];
  assign op7  = inst_i[31:25];
  assign op6  = inst_i[31:26];

  // Opcode groups do not overlap, so order is free
  always_comb begin
    if (op17 == 17'h00020 || op17 == 17'h00022) begin
      cls_o = frontend_pkg::ALU_3R; // ADD.W, SUB.W
    end else if (op10 == 10'h00a) begin
      cls_o = frontend_pkg::ALU_I12;
    end else if (op10 == 10'h0a2) begin
      cls_o = frontend_pkg::LOAD;
    end else if (op10 == 10'h0a6) begin
      cls_o = frontend_pkg::STORE;
    end else if (op7 == 7'h0a) begin
      cls_o = frontend_pkg::LUI;
    end else if (op6 == 6'h14) begin
      cls_o = frontend_pkg::JUMP;
    end else if (op6 == 6'h15) begin
      cls_o = frontend_pkg::JUMP_LINK;
    end else if (op6 == 6'h16 || op6 == 6'h17) begin
      cls_o = frontend_pkg::BRANCH; // BEQ, BNE
    end else begin
      cls_o = frontend_pkg::ILLEGAL;
    end
  end

  always_comb begin
    reg_info_o = '0;
    case (cls_o)
      frontend_pkg::ALU_3R: begin
        reg_info_o.r0 = rk;
        reg_info_o.r1 = rj;
        reg_info_o.w  = rd;
      end
      frontend_pkg::ALU_I12, frontend_pkg::LOAD: begin
        reg_info_o.r1 = rj;
        reg_info_o.w  = rd;
      end
      frontend_pkg::STORE, frontend_pkg::BRANCH: begin
        reg_info_o.r0 = rd; // Store data or compare operand
        reg_info_o.r1 = rj;
      end
      frontend_pkg::LUI: begin
        reg_info_o.w = rd;
      end
      frontend_pkg::JUMP_LINK: begin
        reg_info_o.w = 5'd1; // Link register
      end
      default: begin
        reg_info_o = '0;
      end
    endcase
  end

endmodule

/* src/issue_fifo.sv */
`timescale 1ns/1ns

module issue_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic [1:0]                    wr_num_i,
  input  frontend_pkg::inst_pkt_t [1:0] wr_pkt_i,
  output logic                          wr_ready_o,
  output logic [1:0]                    rd_valid_o,
  output frontend_pkg::inst_pkt_t [1:0] rd_pkt_o,
  input  logic [1:0]                    rd_take_i
);

  localparam int ENTRIES = 2 * FIFO_DEPTH;
  localparam int PTR_W   = $clog2(ENTRIES);
  localparam int IDX_W   = PTR_W - 1;
  localparam int CNT_W   = PTR_W + 1;

  // Entry parity selects the bank
  frontend_pkg::inst_pkt_t bank_q [2][FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [1:0]       wr_n;
  logic [1:0]       rd_n;
  logic [1:0]       taken;

  assign wr_ready_o = count_q <= CNT_W'(ENTRIES - 2);

  assign wr_n  = (wr_ready_o && !flush_i) ? wr_num_i : 2'd0;
  assign taken = rd_take_i & rd_valid_o;
  assign rd_n  = flush_i ? 2'd0 : 2'(taken[0]) + 2'(taken[1]);

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic             lane;
    logic [PTR_W-1:0] entry;
    logic [IDX_W-1:0] idx;

    assign lane  = wr_ptr_q[0] ^ 1'(b); // Lane landing in this bank
    assign entry = wr_ptr_q + PTR_W'(lane);
    assign idx   = entry[PTR_W-1:1];

    always_ff @(posedge clk) begin
      if (wr_n > 2'(lane)) begin
        bank_q[b][idx] <= wr_pkt_i[lane];
      end
    end
  end

  for (genvar l = 0; l < 2; l++) begin : g_rd
    logic [PTR_W-1:0] entry;
    logic [IDX_W-1:0] idx;

    assign entry         = rd_ptr_q + PTR_W'(l);
    assign idx           = entry[PTR_W-1:1];
    assign rd_pkt_o[l]   = bank_q[entry[0]][idx];
    assign rd_valid_o[l] = count_q > CNT_W'(l);
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(wr_n);
      rd_ptr_q <= rd_ptr_q + PTR_W'(rd_n);
      count_q  <= count_q + CNT_W'(wr_n) - CNT_W'(rd_n);
    end
  end

endmodule

/* verif/frontend_checker.sv */
`timescale 1ns/1ns

module frontend_checker (
  input logic       clk,
  input logic       rst_n,
  input logic       req_i,
  input logic       resp_valid_i,
  input logic       wait_i,
  input logic       int_i,
  input logic [1:0] issue_valid_i,
  input logic       wr_ready_i
);

  int unsigned fail_cnt = 0;
  logic        pending_q;
  logic        idle_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else if (req_i) begin
      pending_q <= 1'b1;
    end else if (resp_valid_i) begin
      pending_q <= 1'b0;
    end
  end

  // Mirrors the idle-wait rule at the ports
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_q <= 1'b0;
    end else if (wait_i && !int_i) begin
      idle_q <= 1'b1;
    end else if (int_i) begin
      idle_q <= 1'b0;
    end
  end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (!req_i && issue_valid_i == 2'b00))
    else begin
      $error("request or issue valid high right after reset");
      fail_cnt++;
    end

  valid_order: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid_i[1] |-> issue_valid_i[0])
    else begin
      $error("issue lane 1 valid without lane 0");
      fail_cnt++;
    end

  single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> !pending_q)
    else begin
      $error("second request while one is outstanding");
      fail_cnt++;
    end

  full_no_req: assert property (@(posedge clk) disable iff (!rst_n)
    !wr_ready_i |-> !req_i)
    else begin
      $error("request issued while the issue FIFO is full");
      fail_cnt++;
    end

  idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
    idle_q |-> !req_i)
    else begin
      $error("request issued during idle wait");
      fail_cnt++;
    end

endmodule

bind frontend_top frontend_checker u_checker (
  .clk           (clk),
  .rst_n         (rst_n),
  .req_i         (imem_req_o),
  .resp_valid_i  (imem_resp_valid_i),
  .wait_i        (wait_i),
  .int_i         (int_i),
  .issue_valid_i (issue_valid_o),
  .wr_ready_i    (wr_ready)
);

/* verif/tb_frontend.sv */
`timescale 1ns/1ns

module tb_frontend;

  localparam int          CLK_PERIOD = 4;
  localparam int          FIFO_DEPTH = 4;
  localparam logic [31:0] SEED       = 32'he331a695;
  localparam int          SEQ_PKTS   = 48;
  localparam int          REDIR_PKTS = 16;
  localparam int          BP_PKTS    = 24;
  localparam int          IDLE_PKTS  = 16;
  localparam int          BP_HOLD    = 30;
  localparam int          IDLE_HOLD  = 20;
  // Worst case per packet plus fixed holds and reset
  localparam int TEST_CYCLES = 8 * (SEQ_PKTS + 2 * REDIR_PKTS + BP_PKTS + IDLE_PKTS)
                               + BP_HOLD + IDLE_HOLD + 16;

  logic                          clk;
  logic                          rst_n;
  logic                          imem_req_o;
  frontend_pkg::addr_t           imem_addr_o;
  logic                          imem_resp_valid_i;
  frontend_pkg::word_t [1:0]     imem_resp_data_i;
  logic                          redirect_i;
  frontend_pkg::addr_t           redirect_pc_i;
  logic                          wait_i;
  logic                          int_i;
  logic [1:0]                    issue_valid_o;
  frontend_pkg::inst_pkt_t [1:0] issue_pkt_o;
  logic [1:0]                    issue_take_i;

  frontend_pkg::word_t mem [256];
  frontend_pkg::addr_t exp_pc       = frontend_pkg::RESET_PC;
  int                  pkt_cnt      = 0;
  int                  errors       = 0;
  int                  tests_run    = 0;
  int                  tests_failed = 0;
  bit                  hold_take    = 1'b0;
  string               test_name    = "reset";

  frontend_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Sel 8 and up gives mostly illegal words
  function automatic frontend_pkg::word_t make_word(input int sel);
    frontend_pkg::word_t rnd;
    rnd = $urandom();
    case (sel)
      0: return {rnd[31] ? 17'h00022 : 17'h00020, rnd[14:0]};
      1: return {10'h00a, rnd[21:0]};
      2: return {10'h0a2, rnd[21:0]};
      3: return {10'h0a6, rnd[21:0]};
      4: return {7'h0a, rnd[24:0]};
      5: return {6'h14, rnd[25:0]};
      6: return {6'h15, rnd[25:0]};
      7: return {5'b01011, rnd[26:0]};
      default: return rnd;
    endcase
  endfunction

  function automatic frontend_pkg::reg_info_t regs(input frontend_pkg::reg_idx_t r0,
                                                   input frontend_pkg::reg_idx_t r1,
                                                   input frontend_pkg::reg_idx_t w);
    frontend_pkg::reg_info_t ri;
    ri.r0 = r0;
    ri.r1 = r1;
    ri.w  = w;
    return ri;
  endfunction

  // Expected packet from the class table and the memory word at pc
  function automatic frontend_pkg::inst_pkt_t expect_pkt(input frontend_pkg::addr_t pc);
    frontend_pkg::inst_pkt_t p;
    frontend_pkg::word_t     w;
    w = mem[pc[9:2]];
    p = '0; // Class ILLEGAL and no registers
    p.pc        = pc;
    p.inst      = w;
    p.imm       = w[25:0];
    p.excp.adef = |pc[1:0];
    if (w[31:15] == 17'h00020 || w[31:15] == 17'h00022) begin
      p.cls      = frontend_pkg::ALU_3R;
      p.reg_info = regs(w[14:10], w[9:5], w[4:0]);
    end else if (w[31:22] == 10'h00a || w[31:22] == 10'h0a2) begin
      p.cls      = (w[31:22] == 10'h00a) ? frontend_pkg::ALU_I12 : frontend_pkg::LOAD;
      p.reg_info = regs(5'd0, w[9:5], w[4:0]);
    end else if (w[31:22] == 10'h0a6) begin
      p.cls      = frontend_pkg::STORE;
      p.reg_info = regs(w[4:0], w[9:5], 5'd0);
    end else if (w[31:25] == 7'h0a) begin
      p.cls      = frontend_pkg::LUI;
      p.reg_info = regs(5'd0, 5'd0, w[4:0]);
    end else if (w[31:26] == 6'h14) begin
      p.cls = frontend_pkg::JUMP;
    end else if (w[31:26] == 6'h15) begin
      p.cls      = frontend_pkg::JUMP_LINK;
      p.reg_info = regs(5'd0, 5'd0, 5'd1);
    end else if (w[31:27] == 5'b01011) begin
      p.cls      = frontend_pkg::BRANCH;
      p.reg_info = regs(w[4:0], w[9:5], 5'd0);
    end
    p.excp.ine = (p.cls == frontend_pkg::ILLEGAL);
    return p;
  endfunction

  function automatic logic [1:0] pick_take(input logic [1:0] valid);
    int r;
    r = int'($urandom_range(0, 3));
    if (hold_take || r == 0) begin
      return 2'b00;
    end
    if (r == 3 && valid[1]) begin
      return 2'b11;
    end
    return valid[0] ? 2'b01 : 2'b00;
  endfunction

  function automatic int total_errors();
    return errors + int'(u_dut.u_checker.fail_cnt);
  endfunction

  function automatic int begin_test(input string name);
    test_name = name;
    return total_errors();
  endfunction

  task automatic end_test(input int err_before);
    tests_run++;
    if (total_errors() == err_before) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED, %0d errors", test_name, total_errors() - err_before);
    end
  endtask

  task automatic check_pkt(input frontend_pkg::inst_pkt_t pkt);
    frontend_pkg::inst_pkt_t exp;
    exp = expect_pkt(exp_pc);
    assert (pkt === exp) else begin
      $display("ERROR %s: packet expected %h actual %h", test_name, exp, pkt);
      errors++;
    end
    exp_pc = {exp_pc[31:2] + 30'd1, 2'b00}; // Next slot in program order
    pkt_cnt++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_pkts(input int n);
    int target;
    target = pkt_cnt + n;
    while (pkt_cnt < target) begin
      @(posedge clk);
    end
  endtask

  task automatic redirect_to(input frontend_pkg::addr_t target);
    next_cycle();
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    exp_pc        = target;
    next_cycle();
    redirect_i = 1'b0;
  endtask

  // Instruction memory model with one window in flight
  initial begin : imem_model
    frontend_pkg::addr_t req_addr;
    int                  delay;
    forever begin
      @(negedge clk);
      if (rst_n && imem_req_o) begin
        req_addr = imem_addr_o;
        delay    = int'($urandom_range(1, 4));
        repeat (delay) @(posedge clk);
        #1;
        imem_resp_valid_i   = 1'b1;
        imem_resp_data_i[0] = mem[{req_addr[9:3], 1'b0}];
        imem_resp_data_i[1] = mem[{req_addr[9:3], 1'b1}];
        next_cycle();
        imem_resp_valid_i = 1'b0;
      end
    end
  end

  // Consumer with random legal take masks
  initial begin : consumer
    forever begin
      next_cycle();
      issue_take_i = pick_take(issue_valid_o);
      @(negedge clk); // Taken packets checked mid cycle
      if (rst_n && !redirect_i) begin
        if (issue_take_i[0]) begin
          check_pkt(issue_pkt_o[0]);
        end
        if (issue_take_i[1]) begin
          check_pkt(issue_pkt_o[1]);
        end
      end
    end
  end

  initial begin : watchdog
    #(20 * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int err_before;
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++) begin
      mem[i] = make_word(int'($urandom_range(0, 9)));
    end
    rst_n             = 1'b0;
    imem_resp_valid_i = 1'b0;
    imem_resp_data_i  = '0;
    redirect_i        = 1'b0;
    redirect_pc_i     = '0;
    wait_i            = 1'b0;
    int_i             = 1'b0;
    issue_take_i      = 2'b00;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    err_before = begin_test("sequential");
    wait_pkts(SEQ_PKTS);
    end_test(err_before);

    err_before = begin_test("redirect");
    redirect_to(32'h1c000204); // Upper slot entry
    wait_pkts(REDIR_PKTS);
    end_test(err_before);

    err_before = begin_test("misaligned_redirect");
    redirect_to(32'h1c000306);
    wait_pkts(REDIR_PKTS);
    end_test(err_before);

    err_before = begin_test("back_pressure");
    @(negedge clk);
    hold_take = 1'b1;
    while (issue_valid_o != 2'b11) begin
      @(negedge clk);
    end
    repeat (BP_HOLD) @(negedge clk);
    hold_take = 1'b0;
    wait_pkts(BP_PKTS);
    end_test(err_before);

    err_before = begin_test("idle_wait");
    next_cycle();
    wait_i = 1'b1;
    next_cycle();
    wait_i = 1'b0;
    repeat (IDLE_HOLD) next_cycle();
    int_i = 1'b1;
    next_cycle();
    int_i = 1'b0;
    wait_pkts(IDLE_PKTS);
    end_test(err_before);

    $display("Summary: %0d tests run, %0d failed, %0d errors, %0d packets",
             tests_run, tests_failed, total_errors(), pkt_cnt);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
